// ==== include/exec_core_params.svh ====
`ifndef EXEC_CORE_PARAMS_SVH
`define EXEC_CORE_PARAMS_SVH

// Data path width
`define DATA_W 32

// Register bank size
`define REG_COUNT 32

// Width of a register address, log2 of the count
`define REG_ADDR_W 5

`endif

// ==== verilog/exec_pkg.sv ====
`default_nettype none

`include "exec_core_params.svh"

package exec_pkg;

	////////////////////////////////////////////////////////////
	// ALU operations
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,    // Signed compare
		ALU_SLTU,   // Unsigned compare
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI,
		ALU_PASS_A  // Operand A through, for jump register
	} alu_op_t;

	////////////////////////////////////////////////////////////
	// Decoded instruction, decoder to ALU stage
	////////////////////////////////////////////////////////////

	typedef struct packed
	{
		alu_op_t                 op;
		logic [`REG_ADDR_W-1:0] rs;       // Source A, kept for forwarding
		logic [`REG_ADDR_W-1:0] rt;       // Source B, kept for forwarding
		logic [`REG_ADDR_W-1:0] dest;
		logic                    use_imm;
		logic [`DATA_W-1:0]      imm;      // Already extended
		logic [4:0]              shamt;
		logic                    writes;   // Low for JR, unknown ops, dest 0
		logic                    is_jump;
	} decoded_op_t;

	// One write into the register bank
	typedef struct packed
	{
		logic [`REG_ADDR_W-1:0] addr;
		logic [`DATA_W-1:0]      data;
	} reg_write_t;

endpackage

`default_nettype wire

// ==== verilog/register_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_core_params.svh"

module register_bank
	import exec_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic [`REG_ADDR_W-1:0] rs_addr,
	input  wire logic [`REG_ADDR_W-1:0] rt_addr,
	input  wire logic [`REG_ADDR_W-1:0] dbg_addr,
	input  wire logic                   wr_en,
	input  wire reg_write_t             wr,
	output logic      [`DATA_W-1:0]     rdata_a,
	output logic      [`DATA_W-1:0]     rdata_b,
	output logic      [`DATA_W-1:0]     dbg_rdata
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	logic wr_live;   // Write that actually lands
	logic hit_a;
	logic hit_b;

	assign wr_live = wr_en && (wr.addr != '0);
	assign hit_a = wr_live && (wr.addr == rs_addr);
	assign hit_b = wr_live && (wr.addr == rt_addr);

	////////////////////////////////////////////////////////////
	// Array that reset loads with the register indices
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regs[i] <= `DATA_W'(i);
			end
		end
		else if (wr_live)
		begin
			regs[wr.addr] <= wr.data;
		end
	end

	// Registered reads where a same-edge write wins
	always_ff @(posedge clk)
	begin
		rdata_a <= hit_a ? wr.data : regs[rs_addr];
		rdata_b <= hit_b ? wr.data : regs[rt_addr];
	end

	// Debug tap straight from the array
	assign dbg_rdata = regs[dbg_addr];

endmodule

`default_nettype wire

// ==== verilog/write_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_core_params.svh"

module write_arbiter
	import exec_pkg::*;
(
	input  wire logic       wb_valid,
	input  wire reg_write_t wb,
	input  wire logic       dbg_valid,
	input  wire reg_write_t dbg,
	output logic            wr_en,
	output reg_write_t      wr,
	output logic            dbg_grant
);

	// Writeback always has priority so the pipeline never waits.
	// The debug request only gets the port in a free cycle.

	always_comb
	begin
		wr_en = wb_valid || dbg_valid;
		if (wb_valid)
			wr = wb;
		else
			wr = dbg;
	end

	assign dbg_grant = dbg_valid && !wb_valid;   // One cycle, back to debug port

endmodule

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_core_params.svh"

module instr_decoder
	import exec_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        instr_valid,
	input  wire logic [31:0] instr,
	output logic             dec_valid,
	output decoded_op_t      dec
);

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_SLTIU = 6'h0b;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_LUI   = 6'h0f;

	logic [5:0]         opcode;
	logic [5:0]         funct;
	logic [`DATA_W-1:0] imm_sext;
	logic [`DATA_W-1:0] imm_zext;
	logic               known;
	decoded_op_t        nxt;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign imm_sext = {{(`DATA_W-16){instr[15]}}, instr[15:0]};
	assign imm_zext = {{(`DATA_W-16){1'b0}}, instr[15:0]};

	always_comb
	begin
		known = 1'b1;
		nxt.op = ALU_PASS_A;
		nxt.rs = instr[25:21];
		nxt.rt = instr[20:16];
		nxt.dest = instr[15:11];   // rd for R-type
		nxt.use_imm = 1'b0;
		nxt.imm = imm_sext;
		nxt.shamt = instr[10:6];
		nxt.is_jump = 1'b0;

		case (opcode)
			OP_RTYPE:
			begin
				case (funct)
					6'h00: nxt.op = ALU_SLL;
					6'h02: nxt.op = ALU_SRL;
					6'h03: nxt.op = ALU_SRA;
					6'h08: nxt.is_jump = 1'b1;   // JR, PASS_A carries rs
					6'h21: nxt.op = ALU_ADD;     // ADDU
					6'h23: nxt.op = ALU_SUB;     // SUBU
					6'h24: nxt.op = ALU_AND;
					6'h25: nxt.op = ALU_OR;
					6'h26: nxt.op = ALU_XOR;
					6'h27: nxt.op = ALU_NOR;
					6'h2a: nxt.op = ALU_SLT;
					6'h2b: nxt.op = ALU_SLTU;
					default: known = 1'b0;
				endcase
			end
			OP_ADDIU: nxt.op = ALU_ADD;
			OP_SLTI:  nxt.op = ALU_SLT;
			OP_SLTIU: nxt.op = ALU_SLTU;
			OP_ANDI:  nxt.op = ALU_AND;
			OP_ORI:   nxt.op = ALU_OR;
			OP_XORI:  nxt.op = ALU_XOR;
			OP_LUI:   nxt.op = ALU_LUI;
			default:  known = 1'b0;
		endcase

		// I-type writes rt, logic ops take the zero-extended immediate
		if (opcode != OP_RTYPE)
		begin
			nxt.use_imm = 1'b1;
			nxt.dest = instr[20:16];
			if (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI
				|| opcode == OP_LUI)
				nxt.imm = imm_zext;
		end

		nxt.writes = known && !nxt.is_jump && (nxt.dest != '0);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			dec_valid <= 1'b0;
		else
			dec_valid <= instr_valid;
		dec <= nxt;
	end

endmodule

`default_nettype wire

// ==== verilog/alu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_core_params.svh"

module alu_stage
	import exec_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               dec_valid,
	input  wire decoded_op_t        dec,
	input  wire logic [`DATA_W-1:0] rdata_a,
	input  wire logic [`DATA_W-1:0] rdata_b,
	output logic                    wb_valid,
	output reg_write_t              wb,
	output logic                    jump_valid,
	output logic      [`DATA_W-1:0] jump_target
);

	logic [`DATA_W-1:0] src_a;   // rs after forwarding
	logic [`DATA_W-1:0] src_b;   // rt after forwarding
	logic [`DATA_W-1:0] op_b;
	logic [`DATA_W-1:0] result;

	////////////////////////////////////////////////////////////
	// Forwarding from the result register
	////////////////////////////////////////////////////////////

	// wb_valid here belongs to the instruction one slot ahead.
	// Older results already reach us through the bank bypass.
	assign src_a = (wb_valid && wb.addr == dec.rs) ? wb.data : rdata_a;
	assign src_b = (wb_valid && wb.addr == dec.rt) ? wb.data : rdata_b;

	assign op_b = dec.use_imm ? dec.imm : src_b;

	always_comb
	begin
		case (dec.op)
			ALU_ADD:  result = src_a + op_b;
			ALU_SUB:  result = src_a - op_b;
			ALU_AND:  result = src_a & op_b;
			ALU_OR:   result = src_a | op_b;
			ALU_XOR:  result = src_a ^ op_b;
			ALU_NOR:  result = ~(src_a | op_b);
			ALU_SLT:  result = `DATA_W'($signed(src_a) < $signed(op_b));
			ALU_SLTU: result = `DATA_W'(src_a < op_b);
			ALU_SLL:  result = src_b << dec.shamt;   // Shifts act on rt
			ALU_SRL:  result = src_b >> dec.shamt;
			ALU_SRA:  result = $signed(src_b) >>> dec.shamt;
			ALU_LUI:  result = {op_b[15:0], 16'h0000};
			default:  result = src_a;                 // PASS_A
		endcase
	end

	////////////////////////////////////////////////////////////
	// Result and jump registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb_valid <= 1'b0;
			jump_valid <= 1'b0;
		end
		else
		begin
			wb_valid <= dec_valid && dec.writes;
			jump_valid <= dec_valid && dec.is_jump;
		end
		wb.addr <= dec.dest;
		wb.data <= result;
		jump_target <= src_a;
	end

endmodule

`default_nettype wire

// ==== verilog/debug_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_core_params.svh"

module debug_port
	import exec_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   dbg_write,
	input  wire logic [`REG_ADDR_W-1:0] dbg_waddr,
	input  wire logic [`DATA_W-1:0]     dbg_wdata,
	input  wire logic                   dbg_grant,
	output logic                        dbg_busy,
	output logic                        dbg_req_valid,
	output reg_write_t                  dbg_req
);

	logic       held;       // A request is parked
	reg_write_t held_req;

	// A fresh strobe goes out the same cycle, so a free cycle grants at once
	assign dbg_req_valid = held || dbg_write;
	assign dbg_req = held ? held_req : '{addr: dbg_waddr, data: dbg_wdata};
	assign dbg_busy = dbg_req_valid;

	always_ff @(posedge clk)
	begin
		if (reset)
			held <= 1'b0;
		else if (held)
			held <= !dbg_grant;
		else
			held <= dbg_write && !dbg_grant;   // Park only if not granted now

		if (!held)
			held_req <= '{addr: dbg_waddr, data: dbg_wdata};
	end

endmodule

`default_nettype wire

// ==== verilog/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_core_params.svh"

module exec_core
	import exec_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   instr_valid,
	input  wire logic [31:0]            instr,
	input  wire logic [`REG_ADDR_W-1:0] dbg_addr,
	input  wire logic                   dbg_write,
	input  wire logic [`REG_ADDR_W-1:0] dbg_waddr,
	input  wire logic [`DATA_W-1:0]     dbg_wdata,
	output logic                        res_valid,
	output logic      [`REG_ADDR_W-1:0] res_addr,
	output logic      [`DATA_W-1:0]     res_data,
	output logic                        jump_valid,
	output logic      [`DATA_W-1:0]     jump_target,
	output logic      [`DATA_W-1:0]     dbg_rdata,
	output logic                        dbg_busy
);

	decoded_op_t        dec;
	logic               dec_valid;
	logic [`DATA_W-1:0] rdata_a;
	logic [`DATA_W-1:0] rdata_b;
	reg_write_t         wb_req;
	logic               wb_valid;
	reg_write_t         dbg_req;
	logic               dbg_req_valid;
	logic               dbg_grant;
	reg_write_t         wr;
	logic               wr_en;

	instr_decoder u_decoder (.clk, .reset, .instr_valid, .instr, .dec_valid, .dec);

	// Sources are read off the raw word, alongside decode
	register_bank u_bank (.clk, .reset, .rs_addr(instr[25:21]), .rt_addr(instr[20:16]),
		.dbg_addr, .wr_en, .wr, .rdata_a, .rdata_b, .dbg_rdata);

	alu_stage u_alu (.clk, .reset, .dec_valid, .dec, .rdata_a, .rdata_b,
		.wb_valid, .wb(wb_req), .jump_valid, .jump_target);

	debug_port u_debug (.clk, .reset, .dbg_write, .dbg_waddr, .dbg_wdata, .dbg_grant,
		.dbg_busy, .dbg_req_valid, .dbg_req);

	write_arbiter u_arbiter (.wb_valid, .wb(wb_req), .dbg_valid(dbg_req_valid),
		.dbg(dbg_req), .wr_en, .wr, .dbg_grant);

	// Result strobe is the writeback request itself
	assign res_valid = wb_valid;
	assign res_addr = wb_req.addr;
	assign res_data = wb_req.data;

endmodule

`default_nettype wire

// ==== test/exec_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_core_params.svh"

module exec_model
	import exec_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   instr_valid,
	input  wire logic [31:0]            instr,
	input  wire logic                   dbg_write,
	input  wire reg_write_t             dbg_in,
	input  wire logic [`REG_ADDR_W-1:0] dbg_addr,
	output logic                        res_valid,
	output reg_write_t                  res,
	output logic                        jump_valid,
	output logic      [`DATA_W-1:0]     jump_target,
	output logic                        dbg_busy,
	output logic      [`DATA_W-1:0]     dbg_rdata
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];   // Shadow of the bank
	logic               held;                // Debug write parked behind writeback
	reg_write_t         held_req;
	logic               next_valid;          // Instruction taken at the last edge
	logic               next_jump;
	reg_write_t         next_res;
	logic [`DATA_W-1:0] next_target;

	assign dbg_busy = held || dbg_write;
	assign dbg_rdata = regs[dbg_addr];   // Register 0 is never written here

	always @(posedge clk)
	begin
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] sext;
		logic [`DATA_W-1:0] zext;
		logic [4:0]         sh;
		reg_write_t         req;
		logic               busy;
		logic               known;

		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] = `DATA_W'(i);
			held = 1'b0;
			next_valid = 1'b0;
			next_jump = 1'b0;
			res_valid = 1'b0;
			jump_valid = 1'b0;
		end
		else
		begin
			////////////////////////////////////////////////////////////
			// Writes landing at this edge
			////////////////////////////////////////////////////////////
			busy = held || dbg_write;
			req = held ? held_req : dbg_in;
			if (res_valid)
				regs[res.addr] = res.data;
			else if (busy && req.addr != '0)
				regs[req.addr] = req.data;   // Free cycle, debug goes in
			held = busy && res_valid;
			held_req = req;

			// Sources see every landed write, plus the result one slot ahead
			a = regs[instr[25:21]];
			b = regs[instr[20:16]];
			if (next_valid && next_res.addr == instr[25:21])
				a = next_res.data;
			if (next_valid && next_res.addr == instr[20:16])
				b = next_res.data;

			res_valid = next_valid;
			res = next_res;
			jump_valid = next_jump;
			jump_target = next_target;

			sext = {{16{instr[15]}}, instr[15:0]};
			zext = {16'h0000, instr[15:0]};
			sh = instr[10:6];
			known = 1'b1;
			next_jump = 1'b0;
			next_res.addr = instr[20:16];   // I-type writes rt
			next_res.data = '0;
			case (instr[31:26])
				6'h00:
				begin
					next_res.addr = instr[15:11];
					case (instr[5:0])
						6'h00: next_res.data = b << sh;
						6'h02: next_res.data = b >> sh;
						6'h03: next_res.data = $signed(b) >>> sh;
						6'h08: next_jump = 1'b1;
						6'h21: next_res.data = a + b;
						6'h23: next_res.data = a - b;
						6'h24: next_res.data = a & b;
						6'h25: next_res.data = a | b;
						6'h26: next_res.data = a ^ b;
						6'h27: next_res.data = ~(a | b);
						6'h2a: next_res.data = {31'b0, $signed(a) < $signed(b)};
						6'h2b: next_res.data = {31'b0, a < b};
						default: known = 1'b0;
					endcase
				end
				6'h09: next_res.data = a + sext;
				6'h0a: next_res.data = {31'b0, $signed(a) < $signed(sext)};
				6'h0b: next_res.data = {31'b0, a < sext};
				6'h0c: next_res.data = a & zext;
				6'h0d: next_res.data = a | zext;
				6'h0e: next_res.data = a ^ zext;
				6'h0f: next_res.data = {instr[15:0], 16'h0000};
				default: known = 1'b0;
			endcase
			next_valid = instr_valid && known && !next_jump && next_res.addr != '0;
			next_jump = instr_valid && next_jump;
			next_target = a;
		end
	end

endmodule

`default_nettype wire

// ==== test/exec_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_core_params.svh"

module exec_core_tb
	import exec_pkg::*;
();

	localparam int N_INSTR = 470;   // Over all streams below
	localparam int LIMIT_NS = N_INSTR * 20 * 4 + 4000;

	localparam logic [5:0] R_FUNCTS [11] = '{6'h00, 6'h02, 6'h03, 6'h21, 6'h23, 6'h24,
		6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
	localparam logic [5:0] I_OPS [7] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

	logic                   clk;
	logic                   reset;
	logic                   instr_valid;
	logic [31:0]            instr;
	logic [`REG_ADDR_W-1:0] dbg_addr;
	logic                   dbg_write;
	logic [`REG_ADDR_W-1:0] dbg_waddr;
	logic [`DATA_W-1:0]     dbg_wdata;
	logic                   res_valid;
	logic [`REG_ADDR_W-1:0] res_addr;
	logic [`DATA_W-1:0]     res_data;
	logic                   jump_valid;
	logic [`DATA_W-1:0]     jump_target;
	logic [`DATA_W-1:0]     dbg_rdata;
	logic                   dbg_busy;

	// Model predictions
	logic                   m_res_valid;
	reg_write_t             m_res;
	logic                   m_jump_valid;
	logic [`DATA_W-1:0]     m_jump_target;
	logic                   m_dbg_busy;
	logic [`DATA_W-1:0]     m_dbg_rdata;

	exec_core UUT (.*);

	exec_model u_model (.clk, .reset, .instr_valid, .instr, .dbg_write,
		.dbg_in({dbg_waddr, dbg_wdata}), .dbg_addr, .res_valid(m_res_valid), .res(m_res),
		.jump_valid(m_jump_valid), .jump_target(m_jump_target), .dbg_busy(m_dbg_busy),
		.dbg_rdata(m_dbg_rdata));

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		#(LIMIT_NS);
		$display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
		$display("Done: errors found");
		$fatal(1);
	end

	task automatic report_mismatch(input string what);
		$display("mismatch at %0d ns: %s", $time, what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	// Kind 0 is R-type, 1 is I-type and 2 is JR
	// Registers come from 0 to window-1
	function automatic logic [31:0] random_word(input int window, input int kind);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;

		rs = 5'($urandom % window);
		rt = 5'($urandom % window);
		rd = 5'($urandom % window);
		case (kind)
			0: return {6'h00, rs, rt, rd, 5'($urandom), R_FUNCTS[4'($urandom % 11)]};
			1: return {I_OPS[3'($urandom % 7)], rs, rt, 16'($urandom)};
			default: return {6'h00, rs, 15'h0000, 6'h08};
		endcase
	endfunction

	task automatic run_stream(input int count, input int window, input int min_kind,
		input int max_kind, input int gap, input bit with_dbg);
		for (int n = 0; n < count; n++)
		begin
			@(posedge clk);
			instr_valid <= 1'b1;
			instr <= random_word(window, min_kind + int'($urandom % (max_kind - min_kind + 1)));
			dbg_addr <= 5'($urandom);
			dbg_write <= with_dbg && ($urandom % 6 == 0);   // Some land while busy
			dbg_waddr <= 5'($urandom % window);
			dbg_wdata <= $urandom;
			repeat (gap)
			begin
				@(posedge clk);
				instr_valid <= 1'b0;
				dbg_write <= 1'b0;
			end
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		dbg_write <= 1'b0;
		repeat (4) @(posedge clk);   // Drain so a parked debug write goes in
	endtask

	////////////////////////////////////////////////////////////
	// Every cycle against the model at the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!reset)
		begin
			assert (res_valid == m_res_valid)
			else report_mismatch($sformatf("res_valid %b, expected %b", res_valid, m_res_valid));
			assert (!m_res_valid || (res_addr == m_res.addr && res_data == m_res.data))
			else report_mismatch($sformatf("result r%0d=%h, expected r%0d=%h",
				res_addr, res_data, m_res.addr, m_res.data));
			assert (jump_valid == m_jump_valid)
			else report_mismatch($sformatf("jump_valid %b, expected %b", jump_valid,
				m_jump_valid));
			assert (!m_jump_valid || jump_target == m_jump_target)
			else report_mismatch($sformatf("jump_target %h, expected %h", jump_target,
				m_jump_target));
			assert (dbg_busy == m_dbg_busy)
			else report_mismatch($sformatf("dbg_busy %b, expected %b", dbg_busy, m_dbg_busy));
			assert (dbg_rdata == m_dbg_rdata)
			else report_mismatch($sformatf("dbg_rdata r%0d=%h, expected %h", dbg_addr,
				dbg_rdata, m_dbg_rdata));
		end
	end

	initial
	begin
		void'($urandom(32'h5c3d_2a0d));
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		dbg_addr = '0;
		dbg_write = 1'b0;
		dbg_waddr = '0;
		dbg_wdata = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Each register holds its own index
		for (int i = 0; i < `REG_COUNT; i++)
		begin
			@(posedge clk);
			dbg_addr <= 5'(i);
			@(negedge clk);
			assert (dbg_rdata == `DATA_W'(i))
			else report_mismatch($sformatf("r%0d reads %h after reset", i, dbg_rdata));
		end

		run_stream(60, 32, 0, 0, 2, 1'b0);    // Spaced R-type
		run_stream(150, 8, 0, 1, 0, 1'b0);    // Back to back through forwarding and bypass
		run_stream(80, 8, 1, 1, 0, 1'b0);     // Immediates with dest 0 now and then
		run_stream(60, 8, 0, 2, 0, 1'b0);     // JR mixed in
		run_stream(120, 8, 0, 2, 0, 1'b1);    // Debug writes under continuous issue

		@(posedge clk);
		dbg_addr <= '0;
		@(negedge clk);
		assert (dbg_rdata == '0)
		else report_mismatch($sformatf("r0 reads %h", dbg_rdata));

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== exec_core.f ====
+incdir+include
verilog/exec_pkg.sv
verilog/register_bank.sv
verilog/write_arbiter.sv
verilog/instr_decoder.sv
verilog/alu_stage.sv
verilog/debug_port.sv
verilog/exec_core.sv
test/exec_model.sv
test/exec_core_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
TOP        = exec_core_tb
RTL_TOP    = exec_core
FILELIST   = exec_core.f
OBJ_DIR    = obj_dir
PASS_MSG   = Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The run passes only if the pass message shows up in its output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
